//--- verilog/ciph_pkg.sv
// Shared encodings for the AES round controller; select words are one-hot, handshakes sparse

package ciph_pkg;

  //////////////////////////////
  // Sparse handshake words
  //////////////////////////////

  // HIGH keeps bit 0 set and bit 1 clear, LOW is the mirror image.
  // All-zeros and all-ones are both fault values.
  typedef enum logic [1:0] {
    SP2V_HIGH = 2'b01,
    SP2V_LOW  = 2'b10
  } sp2v_e;

  // Per-rail view of the same word
  typedef struct packed {
    logic rail_n;  // Rail 1, active low
    logic rail_p;  // Rail 0, active high
  } sp2v_rails_t;

  // One word, two readings: encoding check and rail fan-out
  typedef union packed {
    sp2v_e       enc;
    sp2v_rails_t rails;
  } sp2v_u;

  //////////////////////////////
  // Data path selects
  //////////////////////////////

  typedef enum logic [2:0] {
    AES_128 = 3'b001,
    AES_192 = 3'b010,
    AES_256 = 3'b100
  } key_len_e;

  typedef enum logic [2:0] {
    STATE_INIT  = 3'b001,
    STATE_ROUND = 3'b010,
    STATE_CLEAR = 3'b100
  } state_sel_e;

  typedef enum logic [2:0] {
    ADD_RK_INIT  = 3'b001,
    ADD_RK_ROUND = 3'b010,
    ADD_RK_FINAL = 3'b100
  } add_rk_sel_e;

  //////////////////////////////
  // Sizes and round counts
  //////////////////////////////

  localparam int unsigned RndCtrWidth = 4;
  localparam int unsigned NumRails    = 2;  // One rail per bit of sp2v_e

  localparam int unsigned Rounds128 = 10;
  localparam int unsigned Rounds192 = 12;
  localparam int unsigned Rounds256 = 14;

endpackage

//--- verilog/ciph_sp2v_chk.sv
// Pure combinational; a word other than 01 or 10 on either input raises enc_err_o at once
`timescale 1ns/100ps

module ciph_sp2v_chk (
  input  logic                  clk_i,              // Assertion sampling only
  input  logic                  rst_ni,
  input  ciph_pkg::sp2v_u       in_valid_i,
  input  ciph_pkg::sp2v_u       out_ready_i,
  output ciph_pkg::sp2v_rails_t in_valid_rails_o,
  output ciph_pkg::sp2v_rails_t out_ready_rails_o,
  output logic                  enc_err_o
);

  logic in_valid_bad;
  logic out_ready_bad;

  // Encoding check on the enumerated view
  assign in_valid_bad  = !(in_valid_i.enc inside {ciph_pkg::SP2V_HIGH, ciph_pkg::SP2V_LOW});
  assign out_ready_bad = !(out_ready_i.enc inside {ciph_pkg::SP2V_HIGH, ciph_pkg::SP2V_LOW});

  assign enc_err_o = in_valid_bad | out_ready_bad;

  // Rail view goes straight on, each rail picks its own bit
  assign in_valid_rails_o  = in_valid_i.rails;
  assign out_ready_rails_o = out_ready_i.rails;

  //////////////////////////////
  // Assertions
  //////////////////////////////

  // An X here would slip past both rails unnoticed
  enc_err_known_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !$isunknown(enc_err_o)
  ) else $error("enc_err_o is unknown");

endmodule

//--- verilog/ciph_ctrl_rail.sv
// One controller rail; all outputs are Moore, and Inverted flips only the handshake bits
`timescale 1ns/100ps

module ciph_ctrl_rail #(
  parameter bit Inverted = 1'b0   // 1 for the active-low rail
) (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             in_valid_i,
  output logic                             in_ready_o,
  output logic                             out_valid_o,
  input  logic                             out_ready_i,
  input  ciph_pkg::key_len_e               key_len_i,
  input  logic                             err_i,
  output ciph_pkg::state_sel_e             state_sel_o,
  output ciph_pkg::add_rk_sel_e            add_rk_sel_o,
  output logic [ciph_pkg::RndCtrWidth-1:0] rnd_ctr_o,
  output logic                             alert_o
);

  // Sparse state codes, pairwise distance of at least two
  localparam logic [4:0] ST_IDLE   = 5'b01110;
  localparam logic [4:0] ST_INIT   = 5'b11011;
  localparam logic [4:0] ST_ROUND  = 5'b00101;
  localparam logic [4:0] ST_FINISH = 5'b10000;
  localparam logic [4:0] ST_ERROR  = 5'b11101;

  logic [4:0]                       state_d, state_q;
  logic [ciph_pkg::RndCtrWidth-1:0] rnd_ctr_d, rnd_ctr_q;
  logic [ciph_pkg::RndCtrWidth-1:0] num_rnd_d, num_rnd_q;
  logic [ciph_pkg::RndCtrWidth-1:0] num_rnd_sel;
  logic                             in_valid, out_ready;
  logic                             in_ready, out_valid;

  //////////////////////////////
  // Handshake polarity
  //////////////////////////////

  assign in_valid    = in_valid_i ^ Inverted;
  assign out_ready   = out_ready_i ^ Inverted;
  assign in_ready_o  = in_ready ^ Inverted;
  assign out_valid_o = out_valid ^ Inverted;

  // Round count per key length
  always_comb begin : key_len_rounds
    case (key_len_i)
      ciph_pkg::AES_192: num_rnd_sel = ciph_pkg::RndCtrWidth'(ciph_pkg::Rounds192);
      ciph_pkg::AES_256: num_rnd_sel = ciph_pkg::RndCtrWidth'(ciph_pkg::Rounds256);
      default:           num_rnd_sel = ciph_pkg::RndCtrWidth'(ciph_pkg::Rounds128);
    endcase
  end

  //////////////////////////////
  // FSM
  //////////////////////////////

  always_comb begin : fsm_comb
    state_d      = state_q;
    rnd_ctr_d    = rnd_ctr_q;
    num_rnd_d    = num_rnd_q;
    in_ready     = 1'b0;
    out_valid    = 1'b0;
    alert_o      = 1'b0;
    state_sel_o  = ciph_pkg::STATE_CLEAR;
    add_rk_sel_o = ciph_pkg::ADD_RK_INIT;

    case (state_q)
      ST_IDLE: begin
        in_ready = 1'b1;
        if (in_valid) begin
          num_rnd_d = num_rnd_sel;  // Key length sampled on accept
          state_d   = ST_INIT;
        end
      end
      ST_INIT: begin
        state_sel_o = ciph_pkg::STATE_INIT;
        rnd_ctr_d   = ciph_pkg::RndCtrWidth'(1);
        state_d     = ST_ROUND;
      end
      ST_ROUND: begin
        state_sel_o = ciph_pkg::STATE_ROUND;
        if (rnd_ctr_q == num_rnd_q) begin
          add_rk_sel_o = ciph_pkg::ADD_RK_FINAL;  // Last round skips MixColumns
          rnd_ctr_d    = '0;
          state_d      = ST_FINISH;
        end else begin
          add_rk_sel_o = ciph_pkg::ADD_RK_ROUND;
          rnd_ctr_d    = rnd_ctr_q + ciph_pkg::RndCtrWidth'(1);
        end
      end
      ST_FINISH: begin
        out_valid = 1'b1;
        if (out_ready) begin
          state_d = ST_IDLE;  // Completing edge
        end
      end
      ST_ERROR: begin
        alert_o = 1'b1;  // Terminal, only reset leaves
      end
      default: begin
        state_d = ST_ERROR;  // Corrupted state code
      end
    endcase

    // Any fault wins over normal sequencing
    if (err_i) begin
      state_d   = ST_ERROR;
      rnd_ctr_d = '0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : fsm_regs
    if (!rst_ni) begin
      state_q   <= ST_IDLE;
      rnd_ctr_q <= '0;
      num_rnd_q <= ciph_pkg::RndCtrWidth'(ciph_pkg::Rounds128);
    end else begin
      state_q   <= state_d;
      rnd_ctr_q <= rnd_ctr_d;
      num_rnd_q <= num_rnd_d;
    end
  end

  assign rnd_ctr_o = rnd_ctr_q;

  //////////////////////////////
  // Assertions
  //////////////////////////////

  // Result is held under back-pressure
  out_valid_hold_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    out_valid && !out_ready && !err_i |=> out_valid
  ) else $error("out_valid dropped before out_ready");

  rnd_ctr_range_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    rnd_ctr_q <= ciph_pkg::RndCtrWidth'(ciph_pkg::Rounds256)
  ) else $error("round counter beyond Rounds256");

endmodule

//--- verilog/ciph_rail_combine.sv
// Merges rail outputs combinationally; err_o feeds straight back, so rail outputs must stay Moore
`timescale 1ns/100ps

module ciph_rail_combine (
  input  logic                                                 clk_i,
  input  logic                                                 rst_ni,
  input  logic                  [ciph_pkg::NumRails-1:0]       in_ready_i,
  input  logic                  [ciph_pkg::NumRails-1:0]       out_valid_i,
  input  ciph_pkg::state_sel_e  [ciph_pkg::NumRails-1:0]       state_sel_i,
  input  ciph_pkg::add_rk_sel_e [ciph_pkg::NumRails-1:0]       add_rk_sel_i,
  input  logic [ciph_pkg::NumRails-1:0][ciph_pkg::RndCtrWidth-1:0] rnd_ctr_i,
  input  logic                  [ciph_pkg::NumRails-1:0]       alert_i,
  input  logic                                                 enc_err_i,
  input  logic                                                 alert_fatal_i,
  output ciph_pkg::sp2v_e                                      in_ready_o,
  output ciph_pkg::sp2v_e                                      out_valid_o,
  output ciph_pkg::state_sel_e                                 state_sel_o,
  output ciph_pkg::add_rk_sel_e                                add_rk_sel_o,
  output logic                  [ciph_pkg::RndCtrWidth-1:0]    round_o,
  output logic                                                 alert_o,
  output logic                                                 err_o
);

  logic [$bits(ciph_pkg::state_sel_e)-1:0]  state_sel_or;
  logic [$bits(ciph_pkg::add_rk_sel_e)-1:0] add_rk_sel_or;
  logic [ciph_pkg::RndCtrWidth-1:0]         rnd_ctr_or;
  logic                                     mr_err;
  logic                                     hs_err;

  //////////////////////////////
  // Handshake outputs
  //////////////////////////////

  // Rail 0 lands on bit 0, rail 1 on bit 1
  assign in_ready_o  = ciph_pkg::sp2v_e'(in_ready_i);
  assign out_valid_o = ciph_pkg::sp2v_e'(out_valid_i);

  // Rails disagree when the merged word is 00 or 11
  assign hs_err = !(in_ready_o inside {ciph_pkg::SP2V_HIGH, ciph_pkg::SP2V_LOW}) ||
                  !(out_valid_o inside {ciph_pkg::SP2V_HIGH, ciph_pkg::SP2V_LOW});

  //////////////////////////////
  // Selects and counter
  //////////////////////////////

  always_comb begin : combine_rails
    state_sel_or  = '0;
    add_rk_sel_or = '0;
    rnd_ctr_or    = '0;
    for (int i = 0; i < ciph_pkg::NumRails; i++) begin
      state_sel_or  |= state_sel_i[i];
      add_rk_sel_or |= add_rk_sel_i[i];
      rnd_ctr_or    |= rnd_ctr_i[i];
    end

    // A rail that differs from the OR is out of step
    mr_err = 1'b0;
    for (int i = 0; i < ciph_pkg::NumRails; i++) begin
      if (state_sel_or  != state_sel_i[i]  ||
          add_rk_sel_or != add_rk_sel_i[i] ||
          rnd_ctr_or    != rnd_ctr_i[i]) begin
        mr_err = 1'b1;
      end
    end
  end

  assign state_sel_o  = ciph_pkg::state_sel_e'(state_sel_or);
  assign add_rk_sel_o = ciph_pkg::add_rk_sel_e'(add_rk_sel_or);
  assign round_o      = rnd_ctr_or;

  assign alert_o = |alert_i;
  assign err_o   = mr_err | hs_err | enc_err_i | alert_fatal_i;  // Back to both rails

  //////////////////////////////
  // Assertions
  //////////////////////////////

  // No result may leave while the alert is up
  alert_blocks_valid_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    alert_o |-> out_valid_o == ciph_pkg::SP2V_LOW
  ) else $error("out_valid_o not LOW under alert");

endmodule

//--- verilog/ciph_ctrl_top.sv
// One block in flight at a time; key_len_i is only sampled on the accepting edge
`timescale 1ns/100ps

module ciph_ctrl_top (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  ciph_pkg::sp2v_u                  in_valid_i,
  output ciph_pkg::sp2v_e                  in_ready_o,
  output ciph_pkg::sp2v_e                  out_valid_o,
  input  ciph_pkg::sp2v_u                  out_ready_i,
  input  ciph_pkg::key_len_e               key_len_i,
  input  logic                             alert_fatal_i,
  output ciph_pkg::state_sel_e             state_sel_o,
  output ciph_pkg::add_rk_sel_e            add_rk_sel_o,
  output logic [ciph_pkg::RndCtrWidth-1:0] round_o,
  output logic                             alert_o
);

  ciph_pkg::sp2v_rails_t in_valid_rails;
  ciph_pkg::sp2v_rails_t out_ready_rails;
  logic                  enc_err;
  logic                  err;

  // Per-rail outputs, index is the rail number
  logic                  [ciph_pkg::NumRails-1:0]                        rail_in_ready;
  logic                  [ciph_pkg::NumRails-1:0]                        rail_out_valid;
  ciph_pkg::state_sel_e  [ciph_pkg::NumRails-1:0]                        rail_state_sel;
  ciph_pkg::add_rk_sel_e [ciph_pkg::NumRails-1:0]                        rail_add_rk_sel;
  logic                  [ciph_pkg::NumRails-1:0][ciph_pkg::RndCtrWidth-1:0] rail_rnd_ctr;
  logic                  [ciph_pkg::NumRails-1:0]                        rail_alert;

  ciph_sp2v_chk u_sp2v_chk (
    .clk_i             ( clk_i           ),
    .rst_ni            ( rst_ni          ),
    .in_valid_i        ( in_valid_i      ),
    .out_ready_i       ( out_ready_i     ),
    .in_valid_rails_o  ( in_valid_rails  ),
    .out_ready_rails_o ( out_ready_rails ),
    .enc_err_o         ( enc_err         )
  );

  //////////////////////////////
  // Redundant rails
  //////////////////////////////

  ciph_ctrl_rail #(
    .Inverted ( 1'b0 )
  ) u_rail_p (
    .clk_i        ( clk_i                  ),
    .rst_ni       ( rst_ni                 ),
    .in_valid_i   ( in_valid_rails.rail_p  ),
    .in_ready_o   ( rail_in_ready[0]       ),
    .out_valid_o  ( rail_out_valid[0]      ),
    .out_ready_i  ( out_ready_rails.rail_p ),
    .key_len_i    ( key_len_i              ),
    .err_i        ( err                    ),
    .state_sel_o  ( rail_state_sel[0]      ),
    .add_rk_sel_o ( rail_add_rk_sel[0]     ),
    .rnd_ctr_o    ( rail_rnd_ctr[0]        ),
    .alert_o      ( rail_alert[0]          )
  );

  ciph_ctrl_rail #(
    .Inverted ( 1'b1 )
  ) u_rail_n (
    .clk_i        ( clk_i                  ),
    .rst_ni       ( rst_ni                 ),
    .in_valid_i   ( in_valid_rails.rail_n  ),  // Active low
    .in_ready_o   ( rail_in_ready[1]       ),
    .out_valid_o  ( rail_out_valid[1]      ),
    .out_ready_i  ( out_ready_rails.rail_n ),
    .key_len_i    ( key_len_i              ),
    .err_i        ( err                    ),
    .state_sel_o  ( rail_state_sel[1]      ),
    .add_rk_sel_o ( rail_add_rk_sel[1]     ),
    .rnd_ctr_o    ( rail_rnd_ctr[1]        ),
    .alert_o      ( rail_alert[1]          )
  );

  ciph_rail_combine u_rail_combine (
    .clk_i         ( clk_i           ),
    .rst_ni        ( rst_ni          ),
    .in_ready_i    ( rail_in_ready   ),
    .out_valid_i   ( rail_out_valid  ),
    .state_sel_i   ( rail_state_sel  ),
    .add_rk_sel_i  ( rail_add_rk_sel ),
    .rnd_ctr_i     ( rail_rnd_ctr    ),
    .alert_i       ( rail_alert      ),
    .enc_err_i     ( enc_err         ),
    .alert_fatal_i ( alert_fatal_i   ),
    .in_ready_o    ( in_ready_o      ),
    .out_valid_o   ( out_valid_o     ),
    .state_sel_o   ( state_sel_o     ),
    .add_rk_sel_o  ( add_rk_sel_o    ),
    .round_o       ( round_o         ),
    .alert_o       ( alert_o         ),
    .err_o         ( err             )
  );

endmodule

//--- testbench/ciph_ctrl_model.svh
// Cycle model of the round controller; one block in flight, error state held until reset
`ifndef CIPH_CTRL_MODEL_SVH
`define CIPH_CTRL_MODEL_SVH

localparam int M_IDLE   = 0;
localparam int M_INIT   = 1;
localparam int M_ROUND  = 2;
localparam int M_FINISH = 3;
localparam int M_ERROR  = 4;

int                               m_phase;
logic [ciph_pkg::RndCtrWidth-1:0] m_round;
logic [ciph_pkg::RndCtrWidth-1:0] m_rounds;
logic                             m_done;   // Completing edge just seen

function automatic logic [31:0] xorshift32(input logic [31:0] x);
  logic [31:0] y;
  y = x ^ (x << 13);
  y = y ^ (y >> 17);
  y = y ^ (y << 5);
  return y;
endfunction

// Only 01 and 10 are legal handshake words
function automatic logic word_ok(input logic [1:0] w);
  return (w == 2'b01) || (w == 2'b10);
endfunction

function automatic logic [ciph_pkg::RndCtrWidth-1:0] rounds_for(input ciph_pkg::key_len_e kl);
  case (kl)
    ciph_pkg::AES_192: return ciph_pkg::RndCtrWidth'(ciph_pkg::Rounds192);
    ciph_pkg::AES_256: return ciph_pkg::RndCtrWidth'(ciph_pkg::Rounds256);
    default:           return ciph_pkg::RndCtrWidth'(ciph_pkg::Rounds128);
  endcase
endfunction

task automatic model_reset();
  m_phase  = M_IDLE;
  m_round  = '0;
  m_rounds = rounds_for(ciph_pkg::AES_128);
  m_done   = 1'b0;
endtask

// One rising edge, with the inputs the DUT samples at that edge
task automatic model_step(input logic [1:0] iv, input logic [1:0] orr, input logic fatal,
                          input ciph_pkg::key_len_e kl);
  m_done = 1'b0;
  if (!word_ok(iv) || !word_ok(orr) || fatal) begin
    m_phase = M_ERROR;
    m_round = '0;
  end else begin
    case (m_phase)
      M_IDLE: if (iv == 2'b01) begin
        m_rounds = rounds_for(kl);
        m_phase  = M_INIT;
      end
      M_INIT: begin
        m_round = 1;
        m_phase = M_ROUND;
      end
      M_ROUND: if (m_round == m_rounds) begin
        m_round = '0;
        m_phase = M_FINISH;
      end else begin
        m_round++;
      end
      M_FINISH: if (orr == 2'b01) begin
        m_phase = M_IDLE;
        m_done  = 1'b1;
      end
      default: ;  // Error stays
    endcase
  end
endtask

function automatic ciph_pkg::sp2v_e exp_sp2v(input logic high);
  if (high) return ciph_pkg::SP2V_HIGH;
  else return ciph_pkg::SP2V_LOW;
endfunction

function automatic ciph_pkg::state_sel_e exp_state_sel();
  case (m_phase)
    M_INIT:  return ciph_pkg::STATE_INIT;
    M_ROUND: return ciph_pkg::STATE_ROUND;
    default: return ciph_pkg::STATE_CLEAR;
  endcase
endfunction

function automatic ciph_pkg::add_rk_sel_e exp_add_rk_sel();
  if (m_phase != M_ROUND) return ciph_pkg::ADD_RK_INIT;
  else if (m_round == m_rounds) return ciph_pkg::ADD_RK_FINAL;  // Last round
  else return ciph_pkg::ADD_RK_ROUND;
endfunction

`endif

//--- testbench/ciph_ctrl_tb.sv
// Random blocks, stalls and fault injection from a fixed seed; stops at the first mismatch
`timescale 1ns/100ps

module ciph_ctrl_tb;

  localparam logic [31:0] Seed     = 32'hc82a;
  localparam int unsigned NumTests = 300;
  localparam int unsigned MaxGap   = 3;
  localparam int unsigned MaxStall = 8;
  localparam int unsigned WdMargin = 40;  // Covers the first reset
  localparam int unsigned WdCycles =
    NumTests * (ciph_pkg::Rounds256 + MaxStall + MaxGap + 4) + WdMargin;

  logic                             clk_i;
  logic                             rst_ni;
  ciph_pkg::sp2v_u                  in_valid_i;
  ciph_pkg::sp2v_e                  in_ready_o;
  ciph_pkg::sp2v_e                  out_valid_o;
  ciph_pkg::sp2v_u                  out_ready_i;
  ciph_pkg::key_len_e               key_len_i;
  logic                             alert_fatal_i;
  ciph_pkg::state_sel_e             state_sel_o;
  ciph_pkg::add_rk_sel_e            add_rk_sel_o;
  logic [ciph_pkg::RndCtrWidth-1:0] round_o;
  logic                             alert_o;
  logic [31:0]                      rng_state;

  `include "ciph_ctrl_model.svh"

  ciph_ctrl_top UUT (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .in_valid_i    ( in_valid_i    ),
    .in_ready_o    ( in_ready_o    ),
    .out_valid_o   ( out_valid_o   ),
    .out_ready_i   ( out_ready_i   ),
    .key_len_i     ( key_len_i     ),
    .alert_fatal_i ( alert_fatal_i ),
    .state_sel_o   ( state_sel_o   ),
    .add_rk_sel_o  ( add_rk_sel_o  ),
    .round_o       ( round_o       ),
    .alert_o       ( alert_o       )
  );

  initial begin : clock_gen
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;  // 4 ns period
  end

  //////////////////////////////
  // Checks
  //////////////////////////////

  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("=== FAIL ===");
    $fatal(1, "run stopped at %0t", $time);
  endtask

  task automatic check_sp2v(input string name, input ciph_pkg::sp2v_e act,
                            input ciph_pkg::sp2v_e exp);
    if (act !== exp)
      stop_on_error($sformatf("mismatch %s: got %h expected %h", name, act, exp));
  endtask

  task automatic check_state_sel(input ciph_pkg::state_sel_e act, input ciph_pkg::state_sel_e exp);
    if (act !== exp)
      stop_on_error($sformatf("mismatch state_sel_o: got %h expected %h", act, exp));
  endtask

  task automatic check_add_rk_sel(input ciph_pkg::add_rk_sel_e act,
                                  input ciph_pkg::add_rk_sel_e exp);
    if (act !== exp)
      stop_on_error($sformatf("mismatch add_rk_sel_o: got %h expected %h", act, exp));
  endtask

  task automatic check_round(input logic [ciph_pkg::RndCtrWidth-1:0] act,
                             input logic [ciph_pkg::RndCtrWidth-1:0] exp);
    if (act !== exp)
      stop_on_error($sformatf("mismatch round_o: got %h expected %h", act, exp));
  endtask

  task automatic check_alert(input logic act, input logic exp);
    if (act !== exp)
      stop_on_error($sformatf("mismatch alert_o: got %h expected %h", act, exp));
  endtask

  // Moore outputs settle well before the falling edge
  task automatic settle_check();
    @(negedge clk_i);
    check_sp2v("in_ready_o", in_ready_o, exp_sp2v(m_phase == M_IDLE));
    check_sp2v("out_valid_o", out_valid_o, exp_sp2v(m_phase == M_FINISH));
    check_state_sel(state_sel_o, exp_state_sel());
    check_add_rk_sel(add_rk_sel_o, exp_add_rk_sel());
    check_round(round_o, m_round);
    check_alert(alert_o, m_phase == M_ERROR);
  endtask

  //////////////////////////////
  // Stimulus helpers
  //////////////////////////////

  function automatic logic [31:0] rand_next();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  function automatic ciph_pkg::key_len_e pick_key_len();
    case (rand_next() % 3)
      0:       return ciph_pkg::AES_128;
      1:       return ciph_pkg::AES_192;
      default: return ciph_pkg::AES_256;
    endcase
  endfunction

  function automatic logic [1:0] bad_word();
    logic [31:0] r;
    r = rand_next();
    return r[0] ? 2'b11 : 2'b00;
  endfunction

  // Legal word that the current phase must ignore
  function automatic logic [1:0] spare_word();
    logic [31:0] r;
    r = rand_next();
    return r[0] ? ciph_pkg::SP2V_HIGH : ciph_pkg::SP2V_LOW;
  endfunction

  task automatic drive_inputs(input logic [1:0] iv, input logic [1:0] orr,
                              input ciph_pkg::key_len_e kl, input logic fatal);
    in_valid_i    <= iv;
    out_ready_i   <= orr;
    key_len_i     <= kl;
    alert_fatal_i <= fatal;
  endtask

  // Model sees the same inputs as the DUT flops at this edge
  task automatic edge_step();
    @(posedge clk_i);
    model_step(in_valid_i, out_ready_i, alert_fatal_i, key_len_i);
  endtask

  task automatic apply_reset();
    @(posedge clk_i);
    rst_ni <= 1'b0;
    drive_inputs(ciph_pkg::SP2V_LOW, ciph_pkg::SP2V_LOW, ciph_pkg::AES_128, 1'b0);
    model_reset();
    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;
    settle_check();
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin : stimulus
    int unsigned        gap;
    int unsigned        stall;
    int unsigned        inj_at;
    int unsigned        kind;
    int unsigned        cyc;
    int unsigned        err_cyc;
    bit                 inject;
    bit                 finished;
    logic [1:0]         iv;
    logic [1:0]         orr;
    logic               fatal;
    ciph_pkg::key_len_e kl;

    rng_state     = Seed;
    rst_ni        = 1'b0;
    in_valid_i    = ciph_pkg::SP2V_LOW;
    out_ready_i   = ciph_pkg::SP2V_LOW;
    key_len_i     = ciph_pkg::AES_128;
    alert_fatal_i = 1'b0;
    apply_reset();

    for (int t = 0; t < NumTests; t++) begin
      gap      = rand_next() % (MaxGap + 1);
      stall    = rand_next() % (MaxStall + 1);
      inject   = (rand_next() % 5) == 0;
      kind     = rand_next() % 3;
      inj_at   = rand_next() % (gap + 16);  // May land after completion
      cyc      = 0;
      err_cyc  = 0;
      finished = 1'b0;
      while (!finished) begin
        edge_step();
        iv    = ciph_pkg::SP2V_LOW;
        orr   = ciph_pkg::SP2V_LOW;
        fatal = 1'b0;
        if (m_phase == M_ERROR) begin
          // Requests must be ignored while the alert is up
          iv  = ciph_pkg::SP2V_HIGH;
          orr = ciph_pkg::SP2V_HIGH;
          err_cyc++;
        end else if (m_done) begin
          finished = 1'b1;
        end else begin
          if (m_phase != M_IDLE)
            iv = spare_word();  // Busy rails ignore requests
          if (m_phase != M_FINISH)
            orr = spare_word();
          if (m_phase == M_IDLE && cyc >= gap)
            iv = ciph_pkg::SP2V_HIGH;
          if (m_phase == M_FINISH) begin
            if (stall > 0)
              stall--;  // Back-pressure
            else
              orr = ciph_pkg::SP2V_HIGH;
          end
          if (inject && cyc == inj_at) begin
            case (kind)
              0:       iv = bad_word();
              1:       orr = bad_word();
              default: fatal = 1'b1;
            endcase
          end
        end
        kl = pick_key_len();  // Only the accepting edge may use it
        drive_inputs(iv, orr, kl, fatal);
        settle_check();
        cyc++;
        if (err_cyc == 3) begin
          apply_reset();
          finished = 1'b1;
        end
      end
    end

    $display("=== PASS ===");
    $finish;
  end

  initial begin : watchdog
    repeat (WdCycles) @(posedge clk_i);
    stop_on_error("timeout: the run did not finish within its cycle budget");
  end

endmodule

//--- project.f
+incdir+testbench
verilog/ciph_pkg.sv
verilog/ciph_sp2v_chk.sv
verilog/ciph_ctrl_rail.sv
verilog/ciph_rail_combine.sv
verilog/ciph_ctrl_top.sv
testbench/ciph_ctrl_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module ciph_ctrl_tb -f project.f -o Vciph_ctrl_tb

./obj_dir/Vciph_ctrl_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "=== PASS ===" sim.log; then
  echo "simulation passed"
  exit 0
fi
echo "simulation failed"
exit 1
